// File: simmem_pkg.sv
// Shared definitions for the simulated memory delay stage
// ID, address and data widths, response codes and channel structs

package simmem_pkg;

  // Transaction identifier
  parameter int IdWidth = 2;
  parameter int NumIds = 1 << IdWidth;

  // Payload widths
  parameter int AddrWidth = 16;
  parameter int DataWidth = 32;

  // Write response status
  typedef enum logic {
    OKAY   = 1'b0,
    SLVERR = 1'b1
  } resp_code_e;

  // Read address request, sent by the requester
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
  } raddr_req_t;

  // Write address request, sent by the requester
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
  } waddr_req_t;

  // Read data response, sent by the memory
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
  } rdata_resp_t;

  // Write response, sent by the memory
  // No data beat here, only the status
  typedef struct packed {
    logic [IdWidth-1:0] id;
    resp_code_e         code;
  } wresp_t;

endpackage

// File: simmem_resp_bank.sv
// Per-ID response store for one response channel
// One circular FIFO per ID with push, per-ID pop and head view

`timescale 1ns/1ps

module simmem_resp_bank #(
  parameter int PayloadWidth = 8,
  parameter int BankDepth    = 4
) (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,

  input  logic                                            push_i,
  input  logic [simmem_pkg::IdWidth-1:0]                  push_id_i,
  input  logic [PayloadWidth-1:0]                         push_payload_i,
  output logic [simmem_pkg::NumIds-1:0]                   full_o,
  output logic [simmem_pkg::NumIds-1:0]                   nonempty_o,

  input  logic                                            pop_i,
  input  logic [simmem_pkg::IdWidth-1:0]                  pop_id_i,
  output logic [simmem_pkg::NumIds-1:0][PayloadWidth-1:0] head_payload_o
);
  import simmem_pkg::*;

  localparam int PtrWidth = (BankDepth > 1) ? $clog2(BankDepth) : 1;
  localparam int CntWidth = $clog2(BankDepth + 1);

  // Wraps at BankDepth, which need not be a power of two
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(BankDepth - 1)) ? '0 : ptr + PtrWidth'(1);
  endfunction

  for (genvar g = 0; g < NumIds; g++) begin : gen_id
    logic [PayloadWidth-1:0] mem_q [BankDepth];
    logic [PtrWidth-1:0]     wptr_q;
    logic [PtrWidth-1:0]     rptr_q;
    logic [CntWidth-1:0]     count_q;
    logic                    do_push;
    logic                    do_pop;

    assign do_push = push_i && (push_id_i == IdWidth'(g)) && !full_o[g];
    assign do_pop  = pop_i && (pop_id_i == IdWidth'(g)) && nonempty_o[g];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wptr_q  <= '0;
        rptr_q  <= '0;
        count_q <= '0;
      end else begin
        if (do_push) begin
          wptr_q <= next_ptr(wptr_q);
        end
        if (do_pop) begin
          rptr_q <= next_ptr(rptr_q);
        end
        // Simultaneous push and pop leaves the count alone
        if (do_push != do_pop) begin
          count_q <= do_push ? count_q + CntWidth'(1) : count_q - CntWidth'(1);
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (do_push) begin
        mem_q[wptr_q] <= push_payload_i;
      end
    end

    assign full_o[g]         = (count_q == CntWidth'(BankDepth));
    assign nonempty_o[g]     = (count_q != '0);
    assign head_payload_o[g] = mem_q[rptr_q];
  end

endmodule

// File: simmem_message_banks.sv
// Response banks for read data and write responses
// Round-robin release among IDs that are enabled and hold data
// Registered output stage per channel

`timescale 1ns/1ps

module simmem_message_banks #(
  parameter int BankDepth = 4
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  input  logic [simmem_pkg::NumIds-1:0] rdata_release_en_i,
  input  logic [simmem_pkg::NumIds-1:0] wresp_release_en_i,

  input  logic                          rdata_in_valid_i,
  output logic                          rdata_in_ready_o,
  input  simmem_pkg::rdata_resp_t       rdata_resp_i,
  output logic                          rdata_out_valid_o,
  input  logic                          rdata_out_ready_i,
  output simmem_pkg::rdata_resp_t       rdata_resp_o,

  input  logic                          wresp_in_valid_i,
  output logic                          wresp_in_ready_o,
  input  simmem_pkg::wresp_t            wresp_i,
  output logic                          wresp_out_valid_o,
  input  logic                          wresp_out_ready_i,
  output simmem_pkg::wresp_t            wresp_o
);
  import simmem_pkg::*;

  localparam int RdataWidth = $bits(rdata_resp_t);
  localparam int WrespWidth = $bits(wresp_t);

  // First candidate at or after ptr; MSB of the result flags a grant
  function automatic logic [IdWidth:0] rr_pick(input logic [NumIds-1:0] cand,
                                               input logic [IdWidth-1:0] ptr);
    logic [IdWidth-1:0] idx;
    logic [IdWidth:0]   pick;
    pick = '0;
    for (int k = NumIds - 1; k >= 0; k--) begin
      idx = ptr + IdWidth'(k);
      if (cand[idx]) begin
        pick = {1'b1, idx};
      end
    end
    return pick;
  endfunction

  // Read data channel
  logic [NumIds-1:0]                 rdata_full;
  logic [NumIds-1:0]                 rdata_nonempty;
  logic [NumIds-1:0]                 rdata_busy;
  logic [NumIds-1:0]                 rdata_cand;
  logic [NumIds-1:0][RdataWidth-1:0] rdata_heads;
  logic [IdWidth:0]                  rdata_pick;
  logic [IdWidth-1:0]                rdata_ptr_q;
  logic                              rdata_load;
  logic                              rdata_valid_q;
  rdata_resp_t                       rdata_q;

  assign rdata_in_ready_o = !rdata_full[rdata_resp_i.id];

  simmem_resp_bank #(
    .PayloadWidth(RdataWidth),
    .BankDepth   (BankDepth)
  ) rdata_bank_inst (
    .clk_i,
    .arst_n_i,
    .push_i        (rdata_in_valid_i && rdata_in_ready_o),
    .push_id_i     (rdata_resp_i.id),
    .push_payload_i(rdata_resp_i),
    .full_o        (rdata_full),
    .nonempty_o    (rdata_nonempty),
    .pop_i         (rdata_load),
    .pop_id_i      (rdata_pick[IdWidth-1:0]),
    .head_payload_o(rdata_heads)
  );

  // The release enable of the ID sitting in the output stage still refers
  // to that entry, not to the bank head
  assign rdata_busy = rdata_valid_q ? (NumIds'(1) << rdata_q.id) : '0;
  assign rdata_cand = rdata_release_en_i & rdata_nonempty & ~rdata_busy;
  assign rdata_pick = rr_pick(rdata_cand, rdata_ptr_q);
  assign rdata_load = rdata_pick[IdWidth] && (!rdata_valid_q || rdata_out_ready_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_valid_q <= 1'b0;
      rdata_ptr_q   <= '0;
    end else if (rdata_load) begin
      rdata_valid_q <= 1'b1;
      rdata_ptr_q   <= rdata_pick[IdWidth-1:0] + IdWidth'(1);
    end else if (rdata_out_ready_i) begin
      rdata_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_load) begin
      rdata_q <= rdata_resp_t'(rdata_heads[rdata_pick[IdWidth-1:0]]);
    end
  end

  assign rdata_out_valid_o = rdata_valid_q;
  assign rdata_resp_o      = rdata_q;

  // Write response channel
  logic [NumIds-1:0]                 wresp_full;
  logic [NumIds-1:0]                 wresp_nonempty;
  logic [NumIds-1:0]                 wresp_busy;
  logic [NumIds-1:0]                 wresp_cand;
  logic [NumIds-1:0][WrespWidth-1:0] wresp_heads;
  logic [IdWidth:0]                  wresp_pick;
  logic [IdWidth-1:0]                wresp_ptr_q;
  logic                              wresp_load;
  logic                              wresp_valid_q;
  wresp_t                            wresp_q;

  assign wresp_in_ready_o = !wresp_full[wresp_i.id];

  simmem_resp_bank #(
    .PayloadWidth(WrespWidth),
    .BankDepth   (BankDepth)
  ) wresp_bank_inst (
    .clk_i,
    .arst_n_i,
    .push_i        (wresp_in_valid_i && wresp_in_ready_o),
    .push_id_i     (wresp_i.id),
    .push_payload_i(wresp_i),
    .full_o        (wresp_full),
    .nonempty_o    (wresp_nonempty),
    .pop_i         (wresp_load),
    .pop_id_i      (wresp_pick[IdWidth-1:0]),
    .head_payload_o(wresp_heads)
  );

  assign wresp_busy = wresp_valid_q ? (NumIds'(1) << wresp_q.id) : '0;
  assign wresp_cand = wresp_release_en_i & wresp_nonempty & ~wresp_busy;
  assign wresp_pick = rr_pick(wresp_cand, wresp_ptr_q);
  assign wresp_load = wresp_pick[IdWidth] && (!wresp_valid_q || wresp_out_ready_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wresp_valid_q <= 1'b0;
      wresp_ptr_q   <= '0;
    end else if (wresp_load) begin
      wresp_valid_q <= 1'b1;
      wresp_ptr_q   <= wresp_pick[IdWidth-1:0] + IdWidth'(1);
    end else if (wresp_out_ready_i) begin
      wresp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wresp_load) begin
      wresp_q <= wresp_t'(wresp_heads[wresp_pick[IdWidth-1:0]]);
    end
  end

  assign wresp_out_valid_o = wresp_valid_q;
  assign wresp_o           = wresp_q;

endmodule

// File: simmem_releaser.sv
// Deadline tracking for the read and write channels
// Address pass-through with per-ID stall, per-ID deadline FIFOs
// and release enables for the message banks

`timescale 1ns/1ps

module simmem_releaser #(
  parameter int ReadLatency  = 12,
  parameter int WriteLatency = 8,
  parameter int BankDepth    = 4,
  parameter int CounterWidth = 8
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,

  input  logic                           raddr_in_valid_i,
  output logic                           raddr_in_ready_o,
  input  simmem_pkg::raddr_req_t         raddr_req_i,
  output logic                           raddr_out_valid_o,
  input  logic                           raddr_out_ready_i,
  output simmem_pkg::raddr_req_t         raddr_req_o,

  input  logic                           waddr_in_valid_i,
  output logic                           waddr_in_ready_o,
  input  simmem_pkg::waddr_req_t         waddr_req_i,
  output logic                           waddr_out_valid_o,
  input  logic                           waddr_out_ready_i,
  output simmem_pkg::waddr_req_t         waddr_req_o,

  // Observed response output handshakes
  input  logic                           rdata_out_valid_i,
  input  logic                           rdata_out_ready_i,
  input  logic [simmem_pkg::IdWidth-1:0] rdata_out_id_i,
  input  logic                           wresp_out_valid_i,
  input  logic                           wresp_out_ready_i,
  input  logic [simmem_pkg::IdWidth-1:0] wresp_out_id_i,

  output logic [simmem_pkg::NumIds-1:0]  rdata_release_en_o,
  output logic [simmem_pkg::NumIds-1:0]  wresp_release_en_o
);
  import simmem_pkg::*;

  localparam int NumCh    = 2;
  localparam int ChRead   = 0;
  localparam int ChWrite  = 1;
  localparam int PtrWidth = (BankDepth > 1) ? $clog2(BankDepth) : 1;
  localparam int CntWidth = $clog2(BankDepth + 1);

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(BankDepth - 1)) ? '0 : ptr + PtrWidth'(1);
  endfunction

  logic [CounterWidth-1:0]             now_q;
  logic [NumCh-1:0]                    push;
  logic [NumCh-1:0]                    pop;
  logic [NumCh-1:0][IdWidth-1:0]       push_id;
  logic [NumCh-1:0][IdWidth-1:0]       pop_id;
  logic [NumCh-1:0][CounterWidth-1:0]  latency;
  logic [NumCh-1:0][NumIds-1:0]        full;
  logic [NumCh-1:0][NumIds-1:0]        release_en;

  // Free-running timestamp
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      now_q <= '0;
    end else begin
      now_q <= now_q + CounterWidth'(1);
    end
  end

  // Address pass-through, stalled while the ID has no free deadline slot
  assign raddr_req_o       = raddr_req_i;
  assign raddr_out_valid_o = raddr_in_valid_i && !full[ChRead][raddr_req_i.id];
  assign raddr_in_ready_o  = raddr_out_ready_i && !full[ChRead][raddr_req_i.id];

  assign waddr_req_o       = waddr_req_i;
  assign waddr_out_valid_o = waddr_in_valid_i && !full[ChWrite][waddr_req_i.id];
  assign waddr_in_ready_o  = waddr_out_ready_i && !full[ChWrite][waddr_req_i.id];

  assign push[ChRead]     = raddr_in_valid_i && raddr_in_ready_o;
  assign push_id[ChRead]  = raddr_req_i.id;
  assign pop[ChRead]      = rdata_out_valid_i && rdata_out_ready_i;
  assign pop_id[ChRead]   = rdata_out_id_i;
  assign latency[ChRead]  = CounterWidth'(ReadLatency);

  assign push[ChWrite]    = waddr_in_valid_i && waddr_in_ready_o;
  assign push_id[ChWrite] = waddr_req_i.id;
  assign pop[ChWrite]     = wresp_out_valid_i && wresp_out_ready_i;
  assign pop_id[ChWrite]  = wresp_out_id_i;
  assign latency[ChWrite] = CounterWidth'(WriteLatency);

  for (genvar c = 0; c < NumCh; c++) begin : gen_ch
    for (genvar g = 0; g < NumIds; g++) begin : gen_id
      logic [CounterWidth-1:0] dl_q [BankDepth];
      logic [PtrWidth-1:0]     wptr_q;
      logic [PtrWidth-1:0]     rptr_q;
      logic [CntWidth-1:0]     count_q;
      logic [CounterWidth-1:0] slack;
      logic                    do_push;
      logic                    do_pop;

      assign do_push = push[c] && (push_id[c] == IdWidth'(g));
      assign do_pop  = pop[c] && (pop_id[c] == IdWidth'(g)) && (count_q != '0);

      always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
          wptr_q  <= '0;
          rptr_q  <= '0;
          count_q <= '0;
        end else begin
          if (do_push) begin
            wptr_q <= next_ptr(wptr_q);
          end
          if (do_pop) begin
            rptr_q <= next_ptr(rptr_q);
          end
          if (do_push != do_pop) begin
            count_q <= do_push ? count_q + CntWidth'(1) : count_q - CntWidth'(1);
          end
        end
      end

      always_ff @(posedge clk_i) begin
        if (do_push) begin
          dl_q[wptr_q] <= now_q + latency[c];
        end
      end

      // Wrap-safe: deadline reached when now minus deadline is non-negative
      assign slack            = now_q - dl_q[rptr_q];
      assign full[c][g]       = (count_q == CntWidth'(BankDepth));
      assign release_en[c][g] = (count_q != '0) && !slack[CounterWidth-1];
    end
  end

  assign rdata_release_en_o = release_en[ChRead];
  assign wresp_release_en_o = release_en[ChWrite];

endmodule

// File: simmem.sv
// Simulated memory delay stage, top level
// Connects the deadline releaser and the response message banks

`timescale 1ns/1ps

module simmem #(
  parameter int ReadLatency  = 12,
  parameter int WriteLatency = 8,
  parameter int BankDepth    = 4,
  parameter int CounterWidth = 8
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,

  input  logic                    raddr_in_valid_i,
  output logic                    raddr_in_ready_o,
  input  simmem_pkg::raddr_req_t  raddr_req_i,
  output logic                    raddr_out_valid_o,
  input  logic                    raddr_out_ready_i,
  output simmem_pkg::raddr_req_t  raddr_req_o,

  input  logic                    waddr_in_valid_i,
  output logic                    waddr_in_ready_o,
  input  simmem_pkg::waddr_req_t  waddr_req_i,
  output logic                    waddr_out_valid_o,
  input  logic                    waddr_out_ready_i,
  output simmem_pkg::waddr_req_t  waddr_req_o,

  input  logic                    rdata_in_valid_i,
  output logic                    rdata_in_ready_o,
  input  simmem_pkg::rdata_resp_t rdata_resp_i,
  output logic                    rdata_out_valid_o,
  input  logic                    rdata_out_ready_i,
  output simmem_pkg::rdata_resp_t rdata_resp_o,

  input  logic                    wresp_in_valid_i,
  output logic                    wresp_in_ready_o,
  input  simmem_pkg::wresp_t      wresp_i,
  output logic                    wresp_out_valid_o,
  input  logic                    wresp_out_ready_i,
  output simmem_pkg::wresp_t      wresp_o
);
  import simmem_pkg::*;

  logic [NumIds-1:0] rdata_release_en;
  logic [NumIds-1:0] wresp_release_en;

  simmem_releaser #(
    .ReadLatency (ReadLatency),
    .WriteLatency(WriteLatency),
    .BankDepth   (BankDepth),
    .CounterWidth(CounterWidth)
  ) releaser_inst (
    .clk_i,
    .arst_n_i,
    .raddr_in_valid_i,
    .raddr_in_ready_o,
    .raddr_req_i,
    .raddr_out_valid_o,
    .raddr_out_ready_i,
    .raddr_req_o,
    .waddr_in_valid_i,
    .waddr_in_ready_o,
    .waddr_req_i,
    .waddr_out_valid_o,
    .waddr_out_ready_i,
    .waddr_req_o,
    // Deadlines retire on the requester-side transfer
    .rdata_out_valid_i (rdata_out_valid_o),
    .rdata_out_ready_i,
    .rdata_out_id_i    (rdata_resp_o.id),
    .wresp_out_valid_i (wresp_out_valid_o),
    .wresp_out_ready_i,
    .wresp_out_id_i    (wresp_o.id),
    .rdata_release_en_o(rdata_release_en),
    .wresp_release_en_o(wresp_release_en)
  );

  simmem_message_banks #(
    .BankDepth(BankDepth)
  ) message_banks_inst (
    .clk_i,
    .arst_n_i,
    .rdata_release_en_i(rdata_release_en),
    .wresp_release_en_i(wresp_release_en),
    .rdata_in_valid_i,
    .rdata_in_ready_o,
    .rdata_resp_i,
    .rdata_out_valid_o,
    .rdata_out_ready_i,
    .rdata_resp_o,
    .wresp_in_valid_i,
    .wresp_in_ready_o,
    .wresp_i,
    .wresp_out_valid_o,
    .wresp_out_ready_i,
    .wresp_o
  );

endmodule

// File: simmem_assertions.sv
// Bound checks on the simmem response outputs
// Reset values, valid hold under back-pressure, stable payload

`timescale 1ns/1ps

module simmem_assertions (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input logic                    rdata_out_valid_o,
  input logic                    rdata_out_ready_i,
  input simmem_pkg::rdata_resp_t rdata_resp_o,
  input logic                    wresp_out_valid_o,
  input logic                    wresp_out_ready_i,
  input simmem_pkg::wresp_t      wresp_o
);

  // Nothing leaves while reset is held
  reset_quiet_a: assert property (@(posedge clk_i)
    !arst_n_i |-> !rdata_out_valid_o && !wresp_out_valid_o)
    else $error("Response valid high during reset");

  rdata_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rdata_out_valid_o && !rdata_out_ready_i |=> rdata_out_valid_o)
    else $error("Read data valid dropped before ready");

  rdata_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rdata_out_valid_o && !rdata_out_ready_i |=> $stable(rdata_resp_o))
    else $error("Read data changed while stalled");

  wresp_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wresp_out_valid_o && !wresp_out_ready_i |=> wresp_out_valid_o)
    else $error("Write response valid dropped before ready");

  wresp_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wresp_out_valid_o && !wresp_out_ready_i |=> $stable(wresp_o))
    else $error("Write response changed while stalled");

endmodule

bind simmem simmem_assertions assertions_inst (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .rdata_out_valid_o(rdata_out_valid_o),
  .rdata_out_ready_i(rdata_out_ready_i),
  .rdata_resp_o     (rdata_resp_o),
  .wresp_out_valid_o(wresp_out_valid_o),
  .wresp_out_ready_i(wresp_out_ready_i),
  .wresp_o          (wresp_o)
);

// File: tb_simmem.sv
// Testbench for the simulated memory delay stage
// Requester, memory model and response checker driven from a case file

`timescale 1ns/1ps

module tb_simmem;
  import simmem_pkg::*;

  localparam int ReadLatency  = 12;
  localparam int WriteLatency = 8;
  localparam int BankDepth    = 4;
  localparam int MaxLatency   = (ReadLatency > WriteLatency) ? ReadLatency : WriteLatency;

  // One line of the case file
  typedef struct packed {
    int                   ch;
    int                   id;
    logic [AddrWidth-1:0] addr;
    logic [31:0]          payload;
    int                   stall;
  } case_t;

  // Scoreboard entry
  typedef struct packed {
    logic [31:0] payload;
    int          issue;
    int          stall;
    int          idx;
  } exp_t;

  // Request seen by the memory model
  typedef struct packed {
    int                   id;
    logic [AddrWidth-1:0] addr;
    logic [31:0]          payload;
    int                   due;
  } mem_t;

  logic        clk_i;
  logic        arst_n_i;
  logic        raddr_in_valid_i;
  logic        raddr_in_ready_o;
  raddr_req_t  raddr_req_i;
  logic        raddr_out_valid_o;
  logic        raddr_out_ready_i;
  raddr_req_t  raddr_req_o;
  logic        waddr_in_valid_i;
  logic        waddr_in_ready_o;
  waddr_req_t  waddr_req_i;
  logic        waddr_out_valid_o;
  logic        waddr_out_ready_i;
  waddr_req_t  waddr_req_o;
  logic        rdata_in_valid_i;
  logic        rdata_in_ready_o;
  rdata_resp_t rdata_resp_i;
  logic        rdata_out_valid_o;
  logic        rdata_out_ready_i;
  rdata_resp_t rdata_resp_o;
  logic        wresp_in_valid_i;
  logic        wresp_in_ready_o;
  wresp_t      wresp_i;
  logic        wresp_out_valid_o;
  logic        wresp_out_ready_i;
  wresp_t      wresp_o;

  // Per-channel views with index 0 for read and 1 for write
  logic                 addr_in_ready    [2];
  logic                 addr_out_valid   [2];
  logic                 addr_out_ready   [2];
  logic [IdWidth-1:0]   addr_out_id      [2];
  logic [AddrWidth-1:0] addr_out_addr    [2];
  logic                 resp_in_ready    [2];
  logic                 resp_out_valid   [2];
  logic [IdWidth-1:0]   resp_out_id      [2];
  logic [31:0]          resp_out_payload [2];
  logic                 out_rdy          [2];

  case_t cases [$];
  exp_t  exp_q [2][NumIds][$];
  mem_t  mem_req_q [2][$];
  mem_t  pend_q [2][$];
  int    outstanding [2][NumIds];
  int    num_cases;
  int    received;
  int    errors;
  int    full_stalls;
  int    cycle_cnt;
  int    limit;
  int    seed;

  assign addr_in_ready[0]    = raddr_in_ready_o;
  assign addr_in_ready[1]    = waddr_in_ready_o;
  assign addr_out_valid[0]   = raddr_out_valid_o;
  assign addr_out_valid[1]   = waddr_out_valid_o;
  assign addr_out_ready[0]   = raddr_out_ready_i;
  assign addr_out_ready[1]   = waddr_out_ready_i;
  assign addr_out_id[0]      = raddr_req_o.id;
  assign addr_out_id[1]      = waddr_req_o.id;
  assign addr_out_addr[0]    = raddr_req_o.addr;
  assign addr_out_addr[1]    = waddr_req_o.addr;
  assign resp_in_ready[0]    = rdata_in_ready_o;
  assign resp_in_ready[1]    = wresp_in_ready_o;
  assign resp_out_valid[0]   = rdata_out_valid_o;
  assign resp_out_valid[1]   = wresp_out_valid_o;
  assign resp_out_id[0]      = rdata_resp_o.id;
  assign resp_out_id[1]      = wresp_o.id;
  assign resp_out_payload[0] = rdata_resp_o.data;
  assign resp_out_payload[1] = 32'(wresp_o.code);
  assign rdata_out_ready_i   = out_rdy[0];
  assign wresp_out_ready_i   = out_rdy[1];

  simmem #(
    .ReadLatency (ReadLatency),
    .WriteLatency(WriteLatency),
    .BankDepth   (BankDepth),
    .CounterWidth(8)
  ) simmem_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Memory side address ready stalls at random
  initial begin
    seed = 77623;
    forever begin
      @(posedge clk_i);
      #1;
      raddr_out_ready_i = ($random(seed) & 3) != 0;
      waddr_out_ready_i = ($random(seed) & 3) != 0;
    end
  end

  task automatic load_cases();
    int          fd;
    int          n;
    int          ch;
    int          id;
    int          stall;
    logic [15:0] addr;
    logic [31:0] payload;
    string       line;
    fd = $fopen("simmem_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file simmem_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%d %d %h %h %d", ch, id, addr, payload, stall);
        if (n == 5) begin
          cases.push_back('{ch: ch, id: id, addr: addr, payload: payload, stall: stall});
        end
      end
    end
    $fclose(fd);
    num_cases = cases.size();
  endtask

  task automatic drive_address(input int ch, input logic valid, input int id,
                               input logic [AddrWidth-1:0] addr);
    if (ch == 0) begin
      raddr_in_valid_i = valid;
      raddr_req_i.id   = IdWidth'(id);
      raddr_req_i.addr = addr;
    end else begin
      waddr_in_valid_i = valid;
      waddr_req_i.id   = IdWidth'(id);
      waddr_req_i.addr = addr;
    end
  endtask

  task automatic drive_response(input int ch, input logic valid, input int id,
                                input logic [31:0] payload);
    if (ch == 0) begin
      rdata_in_valid_i  = valid;
      rdata_resp_i.id   = IdWidth'(id);
      rdata_resp_i.data = payload;
    end else begin
      wresp_in_valid_i = valid;
      wresp_i.id       = IdWidth'(id);
      wresp_i.code     = resp_code_e'(payload[0]);
    end
  endtask

  // Holds the address until accepted and checks in-ready on every cycle
  task automatic issue_case(input int idx);
    case_t c;
    logic  exp_ready;
    logic  done;
    c = cases[idx];
    mem_req_q[c.ch].push_back('{id: c.id, addr: c.addr, payload: c.payload, due: 0});
    drive_address(c.ch, 1'b1, c.id, c.addr);
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      exp_ready = addr_out_ready[c.ch] && (outstanding[c.ch][c.id] < BankDepth);
      assert (addr_in_ready[c.ch] == exp_ready) else begin
        $display("ERR %0t: case %0d address in-ready %0b, expected %0b",
                 $time, idx, addr_in_ready[c.ch], exp_ready);
        errors++;
      end
      if (addr_out_ready[c.ch] && outstanding[c.ch][c.id] == BankDepth) begin
        full_stalls++;
      end
      done = addr_in_ready[c.ch];
      @(posedge clk_i);
      #1;
    end
    exp_q[c.ch][c.id].push_back('{payload: c.payload, issue: cycle_cnt, stall: c.stall,
                                  idx: idx});
    outstanding[c.ch][c.id]++;
    drive_address(c.ch, 1'b0, 0, '0);
  endtask

  // Answers each accepted address two cycles later
  task automatic memory_model(input int ch);
    mem_t req;
    logic taken;
    logic busy;
    busy = 1'b0;
    forever begin
      @(negedge clk_i);
      if (addr_out_valid[ch] && addr_out_ready[ch]) begin
        if (mem_req_q[ch].size() == 0) begin
          $display("Memory saw an address that no request stands behind at %0t", $time);
          errors++;
        end else begin
          req = mem_req_q[ch].pop_front();
          assert (addr_out_addr[ch] == req.addr && addr_out_id[ch] == IdWidth'(req.id))
            else begin
              $display("ERR %0t: address out %h id %0d, expected %h id %0d",
                       $time, addr_out_addr[ch], addr_out_id[ch], req.addr, req.id);
              errors++;
            end
          req.due = cycle_cnt + 3;
          pend_q[ch].push_back(req);
        end
      end
      // At most BankDepth outstanding per ID, so the bank always has room
      if (busy) begin
        assert (resp_in_ready[ch]) else begin
          $display("ERR %0t: channel %0d response in-ready 0 for id %0d, expected 1",
                   $time, ch, pend_q[ch][0].id);
          errors++;
        end
      end
      taken = busy && resp_in_ready[ch];
      @(posedge clk_i);
      #1;
      if (taken) begin
        req = pend_q[ch].pop_front();
        busy = 1'b0;
        drive_response(ch, 1'b0, 0, '0);
      end
      if (!busy && pend_q[ch].size() != 0 && pend_q[ch][0].due <= cycle_cnt) begin
        busy = 1'b1;
        drive_response(ch, 1'b1, pend_q[ch][0].id, pend_q[ch][0].payload);
      end
    end
  endtask

  task automatic check_response(input int ch, input int id, input int seen);
    exp_t e;
    int   elapsed;
    int   lat;
    logic bad;
    lat = (ch == 0) ? ReadLatency : WriteLatency;
    bad = 1'b0;
    if (exp_q[ch][id].size() == 0) begin
      $display("Response on channel %0d id %0d arrived with nothing outstanding at %0t",
               ch, id, $time);
      errors++;
      return;
    end
    e = exp_q[ch][id].pop_front();
    elapsed = seen - e.issue;
    assert (resp_out_payload[ch] == e.payload) else begin
      $display("ERR %0t: case %0d payload %h, expected %h",
               $time, e.idx, resp_out_payload[ch], e.payload);
      errors++;
      bad = 1'b1;
    end
    assert (elapsed >= lat) else begin
      $display("ERR %0t: case %0d appeared after %0d cycles, minimum %0d",
               $time, e.idx, elapsed, lat);
      errors++;
      bad = 1'b1;
    end
    received++;
    $display("case %0d %s id %0d latency %0d %s", e.idx, (ch == 0) ? "read" : "write",
             id, elapsed, bad ? "mismatch" : "ok");
  endtask

  // Requester side holding out-ready low for the stall of the presented entry
  task automatic drain_channel(input int ch);
    int hold;
    int id;
    int seen;
    hold = -1;
    seen = 0;
    forever begin
      @(negedge clk_i);
      if (resp_out_valid[ch]) begin
        id = int'(resp_out_id[ch]);
        if (out_rdy[ch]) begin
          check_response(ch, id, seen);
          @(posedge clk_i);
          #1;
          out_rdy[ch] = 1'b0;
          if (outstanding[ch][id] > 0) begin
            outstanding[ch][id]--;
          end
        end else begin
          if (hold < 0) begin
            hold = (exp_q[ch][id].size() != 0) ? exp_q[ch][id][0].stall : 0;
            // Cycle in which the presented entry first showed valid
            seen = cycle_cnt;
          end
          if (hold == 0) begin
            @(posedge clk_i);
            #1;
            out_rdy[ch] = 1'b1;
            hold = -1;
          end else begin
            hold--;
          end
        end
      end
    end
  endtask

  initial memory_model(0);
  initial memory_model(1);
  initial drain_channel(0);
  initial drain_channel(1);

  // Cycle limit derived from the number of cases
  initial begin
    wait (num_cases > 0);
    limit = num_cases * (MaxLatency + 40);
    while (cycle_cnt < limit) begin
      @(posedge clk_i);
    end
    $display("Timeout after %0d cycles with %0d of %0d responses", limit, received, num_cases);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    arst_n_i          = 1'b1;
    raddr_in_valid_i  = 1'b0;
    raddr_req_i       = '0;
    raddr_out_ready_i = 1'b1;
    waddr_in_valid_i  = 1'b0;
    waddr_req_i       = '0;
    waddr_out_ready_i = 1'b1;
    rdata_in_valid_i  = 1'b0;
    rdata_resp_i      = '0;
    wresp_in_valid_i  = 1'b0;
    wresp_i           = '0;
    out_rdy[0]        = 1'b0;
    out_rdy[1]        = 1'b0;
    load_cases();
    #1 arst_n_i = 1'b0;
    repeat (16) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    @(negedge clk_i);
    assert (!raddr_out_valid_o && !waddr_out_valid_o && !rdata_out_valid_o &&
            !wresp_out_valid_o) else begin
      $display("ERR %0t: an out-valid is high right after reset", $time);
      errors++;
    end
    @(posedge clk_i);
    #1;
    for (int i = 0; i < num_cases; i++) begin
      issue_case(i);
    end
    while (received < num_cases) begin
      @(posedge clk_i);
    end
    // Idle window to catch duplicated responses
    repeat (20) @(posedge clk_i);
    assert (received == num_cases && !rdata_out_valid_o && !wresp_out_valid_o) else begin
      $display("ERR %0t: %0d responses for %0d cases, or a response left over",
               $time, received, num_cases);
      errors++;
    end
    assert (full_stalls > 0) else begin
      $display("Address in-ready never dropped for an ID holding %0d requests", BankDepth);
      errors++;
    end
    $display("Summary: %0d cases, %0d responses, %0d full-ID stall cycles, %0d errors",
             num_cases, received, full_stalls, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: simmem_cases.txt
# ch id addr payload stall
# ch 0 read, 1 write; payload is read data or write code (hex); stall is out-ready hold cycles
0 0 0100 deadbeef 0
1 0 0200 00000000 0
0 1 0104 12345678 2
1 1 0204 00000001 0
0 2 0108 a5a5a5a5 0
0 3 010c 0badf00d 3
1 2 0208 00000000 1
1 3 020c 00000001 0
0 2 0110 11111111 0
0 2 0114 22222222 4
0 2 0118 33333333 0
0 2 011c 44444444 1
0 2 0120 55555555 0
1 0 0210 00000001 5
1 0 0214 00000000 0
1 0 0218 00000001 0
1 0 021c 00000000 0
1 0 0220 00000001 2
0 1 0124 cafef00d 0

// File: list.f
simmem_pkg.sv
simmem_resp_bank.sv
simmem_message_banks.sv
simmem_releaser.sv
simmem.sv
simmem_assertions.sv
tb_simmem.sv

// File: Makefile
SRCS := $(shell cat list.f)

.PHONY: all run clean

all: obj_dir/Vtb_simmem

obj_dir/Vtb_simmem: list.f $(SRCS)
	verilator --binary --assert --top-module tb_simmem -Wno-fatal -f list.f -o Vtb_simmem

sim.log: obj_dir/Vtb_simmem simmem_cases.txt
	./obj_dir/Vtb_simmem > sim.log 2>&1 || true

run: sim.log
	@cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
